// File: common/afu_pkg.sv
/* Frame copy read path
   Accelerator-side types */

package afu_pkg;

   import cci_pkg::t_tx_header;
   import cci_pkg::CCI_ADDR_W;

   // Longest frame that the line counters and mdata index can describe
   localparam int MAX_FRAME_LINES = 4095;

   // Width of a line index, which also fills the low part of mdata
   localparam int LINE_IDX_W = $clog2(MAX_FRAME_LINES + 1);

   // Software-visible state delivered by the CSR block
   // start is a one-cycle pulse that kicks off a new frame
   typedef struct packed {
      logic                  afu_en;
      logic                  start;
      logic [CCI_ADDR_W-1:0] src_base;
      logic [CCI_ADDR_W-1:0] dst_base;
      logic [15:0]           dst_stride;
      logic [LINE_IDX_W-1:0] frame_lines;
   } t_csr_afu_state;

   // One client's request toward the read arbiter
   // The client holds both fields steady until its grant arrives
   typedef struct packed {
      logic       request;
      t_tx_header read_header;
   } t_frame_arb;

   // One-cycle grants returned by the read arbiter
   typedef struct packed {
      logic reader_grant;
      logic writer_grant;
      logic status_grant;
   } t_channel_grant_arb;

   // Client ids placed in the top bits of mdata
   typedef enum logic [1:0] {
      CLIENT_READER = 2'd0,
      CLIENT_WRITER = 2'd1,
      CLIENT_STATUS = 2'd2
   } t_client_id;

   // State of the frame address generators
   typedef enum logic {
      IDLE,
      ISSUE
   } t_gen_state;

endpackage

// File: common/cci_pkg.sv
/* Frame copy read path
   Host channel types and constants */

package cci_pkg;

   // Width of a cache-line address on the host channel
   localparam int CCI_ADDR_W = 32;

   // Width of the metadata field that comes back with a read response
   localparam int CCI_MDATA_W = 14;

   // The channel queue still takes this many requests after almost-full
   // rises, since requests already on the wire have to land somewhere
   localparam int CCI_AF_SLACK = 4;

   // Counter width that can hold 0 up to CCI_AF_SLACK
   localparam int CCI_AF_CNT_W = $clog2(CCI_AF_SLACK + 1);

   // Read request opcodes
   // Shared reads serve the reader and status polls, and invalidating
   // reads serve the writer, which will own the line it merges into
   typedef enum logic [3:0] {
      RD_LINE_S = 4'h4,
      RD_LINE_I = 4'h6
   } t_cci_req;

   // Read request header
   // The top 2 bits of mdata carry the client id and the low 12 bits
   // carry the line index within the frame
   typedef struct packed {
      t_cci_req               opcode;
      logic [CCI_ADDR_W-1:0]  address;
      logic [CCI_MDATA_W-1:0] mdata;
   } t_tx_header;

   // Channel-0 request packet as it leaves the accelerator
   typedef struct packed {
      t_tx_header header;
      logic       rdvalid;
   } t_tx_c0;

endpackage

// File: frame_reader/frame_reader.sv
/* Source frame line reader */

module frame_reader (
   input  logic                    clk,
   input  logic                    resetb,
   input  afu_pkg::t_csr_afu_state csr,
   input  logic                    grant,
   output afu_pkg::t_frame_arb     req
);

   import cci_pkg::*;
   import afu_pkg::*;

   t_gen_state            state;
   logic [LINE_IDX_W-1:0] line_idx;
   logic                  last_line;

   // True when the line now on offer is the final one of the frame
   assign last_line = (line_idx == csr.frame_lines - 1'b1);

   // Frame walk
   // start arms a new frame from line 0 and each grant moves on by one
   // line, until frame_lines of them have been accepted
   always_ff @(posedge clk) begin
      if (!resetb) begin
         state    <= IDLE;
         line_idx <= '0;
      end else if (csr.start) begin
         // An empty frame leaves the reader idle
         state    <= (csr.frame_lines != '0) ? ISSUE : IDLE;
         line_idx <= '0;
      end else if (state == ISSUE && grant) begin
         if (last_line) begin
            state    <= IDLE;
            line_idx <= '0;
         end else begin
            line_idx <= line_idx + 1'b1;
         end
      end
   end

   // Request and header come straight from the walk registers
   // They stay put while no grant arrives, as the handshake asks
   always_comb begin
      req.request                 = (state == ISSUE);
      req.read_header.opcode      = RD_LINE_S;
      req.read_header.address     = csr.src_base + CCI_ADDR_W'(line_idx);
      // Response steering tag, client id on top of the line index
      req.read_header.mdata       = {CLIENT_READER, line_idx};
   end

endmodule

// File: frame_writer/frame_writer.sv
/* Destination frame line fetcher */

module frame_writer (
   input  logic                    clk,
   input  logic                    resetb,
   input  afu_pkg::t_csr_afu_state csr,
   input  logic                    grant,
   output afu_pkg::t_frame_arb     req
);

   import cci_pkg::*;
   import afu_pkg::*;

   t_gen_state            state;
   logic [LINE_IDX_W-1:0] line_idx;
   logic                  last_line;

   // Address of the destination line on offer
   // It steps by the stride, so a running sum avoids a multiplier
   logic [CCI_ADDR_W-1:0] line_addr;

   assign last_line = (line_idx == csr.frame_lines - 1'b1);

   // Control part of the walk
   always_ff @(posedge clk) begin
      if (!resetb) begin
         state    <= IDLE;
         line_idx <= '0;
      end else if (csr.start) begin
         // Nothing to fetch for an empty frame
         state    <= (csr.frame_lines != '0) ? ISSUE : IDLE;
         line_idx <= '0;
      end else if (state == ISSUE && grant) begin
         if (last_line) begin
            state    <= IDLE;
            line_idx <= '0;
         end else begin
            line_idx <= line_idx + 1'b1;
         end
      end
   end

   // Running destination address
   // Loaded at start and moved by one stride for every accepted line
   // Its value only matters while a request is up
   always_ff @(posedge clk) begin
      if (csr.start) begin
         line_addr <= csr.dst_base;
      end else if (state == ISSUE && grant) begin
         line_addr <= line_addr + CCI_ADDR_W'(csr.dst_stride);
      end
   end

   // The writer asks for ownership, since it will merge into these lines
   always_comb begin
      req.request             = (state == ISSUE);
      req.read_header.opcode  = RD_LINE_I;
      req.read_header.address = line_addr;
      // Writer tag keeps its responses apart from the reader's
      req.read_header.mdata   = {CLIENT_WRITER, line_idx};
   end

endmodule

// File: qa_read_path.f
common/cci_pkg.sv
common/afu_pkg.sv
rtl/cci_can_issue.sv
rtl/cci_read_arbiter.sv
frame_reader/frame_reader.sv
frame_writer/frame_writer.sv
rtl/qa_read_path.sv
tests/qa_read_path_asserts.sv
tests/qa_read_path_tb.sv

// File: rtl/cci_can_issue.sv
/* Almost-full issue throttle */

module cci_can_issue (
   input  logic clk,
   input  logic resetb,
   input  logic almostfull,
   input  logic issue,
   output logic can_issue
);

   import cci_pkg::*;

   // Issues counted since almost-full went high
   logic [CCI_AF_CNT_W-1:0] af_count;
   logic                    slack_left;

   // There is room for more while fewer than CCI_AF_SLACK requests have
   // gone out under almost-full
   assign slack_left = (af_count < CCI_AF_CNT_W'(CCI_AF_SLACK));

   // With almost-full low the channel takes anything, otherwise only
   // the remaining slack may still be used
   assign can_issue = !almostfull || slack_left;

   // The counter rests at zero while almost-full is low
   // Each issue made under almost-full uses one slot of slack, and the
   // count stops at the limit until almost-full drops again
   always_ff @(posedge clk) begin
      if (!resetb) begin
         af_count <= '0;
      end else if (!almostfull) begin
         af_count <= '0;
      end else if (issue && slack_left) begin
         af_count <= af_count + 1'b1;
      end
   end

endmodule

// File: rtl/cci_read_arbiter.sv
/* Channel-0 read arbiter */

module cci_read_arbiter (
   input  logic                        clk,
   input  logic                        resetb,
   input  afu_pkg::t_csr_afu_state     csr,
   input  afu_pkg::t_frame_arb         status_mgr_req,
   input  afu_pkg::t_frame_arb         frame_writer,
   input  afu_pkg::t_frame_arb         frame_reader,
   output afu_pkg::t_channel_grant_arb read_grant,
   output cci_pkg::t_tx_c0             tx0,
   input  logic                        tx0_almostfull
);

   import cci_pkg::*;
   import afu_pkg::*;

   // Priority state
   // The reader normally wins, but right after a reader grant a waiting
   // writer gets its turn so that neither stream starves
   typedef enum logic {
      FAVOR_FRAME_READER,
      FAVOR_FRAME_WRITER
   } t_arb_state;

   t_arb_state state;
   t_arb_state next_state;

   logic       cci_ready;
   logic       can_issue;
   logic       issue;
   t_tx_header header;

   // Registered packet toward the channel
   t_tx_header tx0_header_q;
   logic       tx0_rdvalid_q;

   // Issue needs room on the channel and software must have enabled us
   assign can_issue = cci_ready && csr.afu_en;

   // Any grant is an issue that the throttle has to count
   assign issue = read_grant.reader_grant | read_grant.writer_grant | read_grant.status_grant;

   cci_can_issue issue_control (
      .clk        (clk),
      .resetb     (resetb),
      .almostfull (tx0_almostfull),
      .issue      (issue),
      .can_issue  (cci_ready)
   );

   always_ff @(posedge clk) begin
      if (!resetb) begin
         state <= FAVOR_FRAME_READER;
      end else begin
         state <= next_state;
      end
   end

   // Hand priority to the writer for one cycle after each reader grant
   assign next_state = read_grant.reader_grant ? FAVOR_FRAME_WRITER : FAVOR_FRAME_READER;

   // Grant selection and header mux
   // Status polls only get through when both frame clients are quiet
   always_comb begin
      read_grant = '0;
      // Reader header is the default, so no extra zero leg in the mux
      header = frame_reader.read_header;
      if (frame_reader.request &&
          (state == FAVOR_FRAME_READER || !frame_writer.request)) begin
         read_grant.reader_grant = can_issue;
      end else if (frame_writer.request) begin
         header = frame_writer.read_header;
         read_grant.writer_grant = can_issue;
      end else if (status_mgr_req.request) begin
         header = status_mgr_req.read_header;
         read_grant.status_grant = can_issue;
      end
   end

   // Header is payload and just follows the mux every cycle
   always_ff @(posedge clk) begin
      tx0_header_q <= header;
   end

   // rdvalid marks the granted header one cycle after its grant
   always_ff @(posedge clk) begin
      if (!resetb) begin
         tx0_rdvalid_q <= 1'b0;
      end else begin
         tx0_rdvalid_q <= issue;
      end
   end

   assign tx0.header  = tx0_header_q;
   assign tx0.rdvalid = tx0_rdvalid_q;

endmodule

// File: rtl/qa_read_path.sv
/* Frame copy read-request path */

module qa_read_path (
   input  logic                    clk,
   input  logic                    resetb,
   input  afu_pkg::t_csr_afu_state csr,
   input  afu_pkg::t_frame_arb     status_req,
   output logic                    status_grant,
   output cci_pkg::t_tx_c0         tx0,
   input  logic                    tx0_almostfull
);

   import afu_pkg::*;

   // Requests of the two frame clients
   t_frame_arb         reader_req;
   t_frame_arb         writer_req;

   // Grants back from the arbiter, one bit per client
   t_channel_grant_arb read_grant;

   // Source side walks the frame one line after another
   frame_reader frame_reader_i (
      .clk    (clk),
      .resetb (resetb),
      .csr    (csr),
      .grant  (read_grant.reader_grant),
      .req    (reader_req)
   );

   // Destination side fetches strided lines to merge into
   frame_writer frame_writer_i (
      .clk    (clk),
      .resetb (resetb),
      .csr    (csr),
      .grant  (read_grant.writer_grant),
      .req    (writer_req)
   );

   // Single channel-0 stream out of three request sources
   // The status poll comes in from outside and gets the lowest priority
   cci_read_arbiter cci_read_arbiter_i (
      .clk            (clk),
      .resetb         (resetb),
      .csr            (csr),
      .status_mgr_req (status_req),
      .frame_writer   (writer_req),
      .frame_reader   (reader_req),
      .read_grant     (read_grant),
      .tx0            (tx0),
      .tx0_almostfull (tx0_almostfull)
   );

   // Status grant goes back out to the external status manager
   assign status_grant = read_grant.status_grant;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the read path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f qa_read_path.f \
   --top-module qa_read_path_tb -o qa_read_path_sim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

output=$(./obj_dir/qa_read_path_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
   exit 0
fi
exit 1

// File: tests/qa_read_path_asserts.sv
/* Read arbiter assertions */

module qa_read_path_asserts (
   input logic                        clk,
   input logic                        resetb,
   input afu_pkg::t_csr_afu_state     csr,
   input afu_pkg::t_channel_grant_arb read_grant,
   input cci_pkg::t_tx_c0             tx0
);

   timeunit 1ns;
   timeprecision 1ns;

   logic [2:0] grant_vec;
   logic       grant_any;

   assign grant_vec = {read_grant.reader_grant, read_grant.writer_grant, read_grant.status_grant};
   assign grant_any = |grant_vec;

   // Only one client may own the channel in a cycle
   one_grant: assert property (@(posedge clk) disable iff (!resetb) $onehot0(grant_vec))
      else $error("More than one read grant in the same cycle");

   // A disabled accelerator must stay silent on the channel
   no_grant_disabled: assert property (@(posedge clk) disable iff (!resetb)
      !csr.afu_en |-> !grant_any)
      else $error("Read grant given while afu_en is low");

   // The output register turns each grant into exactly one packet
   rdvalid_after_grant: assert property (@(posedge clk) disable iff (!resetb)
      grant_any |=> tx0.rdvalid)
      else $error("Grant not followed by rdvalid on the next cycle");

   no_rdvalid_without_grant: assert property (@(posedge clk) disable iff (!resetb)
      !grant_any |=> !tx0.rdvalid)
      else $error("rdvalid seen without a grant on the cycle before");

endmodule

bind cci_read_arbiter qa_read_path_asserts arbiter_asserts_i (
   .clk        (clk),
   .resetb     (resetb),
   .csr        (csr),
   .read_grant (read_grant),
   .tx0        (tx0)
);

// File: tests/qa_read_path_tb.sv
/* Frame copy read path testbench */

module qa_read_path_tb;

   timeunit 1ns;
   timeprecision 1ns;

   import cci_pkg::*;
   import afu_pkg::*;

   localparam int NUM_FRAMES = 4;
   localparam int NUM_POLLS  = 3;

   logic           clk;
   logic           resetb;
   t_csr_afu_state csr;
   t_frame_arb     status_req;
   logic           status_grant;
   t_tx_c0         tx0;
   logic           tx0_almostfull;

   // Expected frame parameters
   // Index 2 of next_line belongs to the status client
   logic [31:0] src_base;
   logic [31:0] dst_base;
   logic [15:0] dst_stride;
   logic [31:0] status_base;
   int          cur_lines   = 0;
   int          status_sent = 0;
   int          next_line[3] = '{0, 0, 0};
   int          frame_len[NUM_FRAMES];
   int          total_lines = 0;
   int          error_count = 0;

   // Comparator history aligned to the grant cycle of the packet now on tx0
   logic afu_en_d       = 1'b0;
   logic af_d           = 1'b0;
   logic status_grant_d = 1'b0;
   logic prev_valid     = 1'b0;
   int   prev_client    = 0;
   int   af_packets     = 0;
   logic first_pkt      = 1'b0;

   qa_read_path qa_read_path_i (
      .clk            (clk),
      .resetb         (resetb),
      .csr            (csr),
      .status_req     (status_req),
      .status_grant   (status_grant),
      .tx0            (tx0),
      .tx0_almostfull (tx0_almostfull)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   // Header that client c should send for its line i
   function automatic t_tx_header expected_header(input int client, input int line);
      t_tx_header h;
      h.mdata = {client[1:0], line[11:0]};
      case (client)
         0: begin
            h.opcode  = RD_LINE_S;
            h.address = src_base + 32'(line);
         end
         1: begin
            h.opcode  = RD_LINE_I;
            h.address = dst_base + 32'(line) * 32'(dst_stride);
         end
         default: begin
            h.opcode  = RD_LINE_S;
            h.address = status_base + 32'(line);
         end
      endcase
      return h;
   endfunction

   function automatic logic frame_done();
      return (next_line[0] >= cur_lines) && (next_line[1] >= cur_lines);
   endfunction

   task automatic note_error(input string msg);
      $display("Error: %s", msg);
      error_count++;
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("Fail %s expected %0h got %0h", name, expected, actual);
      error_count++;
   endtask

   // Start a new random frame with a one-cycle start pulse
   task automatic start_frame(input int len);
      logic [31:0] src;
      logic [31:0] dst;
      logic [15:0] stride;
      src    = $urandom;
      dst    = $urandom;
      stride = 16'(1 + $urandom % 64);
      @(posedge clk);
      csr.src_base    <= src;
      csr.dst_base    <= dst;
      csr.dst_stride  <= stride;
      csr.frame_lines <= 12'(len);
      csr.start       <= 1'b1;
      src_base        <= src;
      dst_base        <= dst;
      dst_stride      <= stride;
      cur_lines       <= len;
      @(posedge clk);
      csr.start <= 1'b0;
   endtask

   task automatic wait_frame_done();
      repeat (3) @(posedge clk);
      while (!frame_done()) @(posedge clk);
   endtask

   // The status manager side holds its request until the grant is seen
   task automatic issue_status_poll();
      @(posedge clk);
      status_req.request             <= 1'b1;
      status_req.read_header.opcode  <= RD_LINE_S;
      status_req.read_header.address <= status_base + 32'(status_sent);
      status_req.read_header.mdata   <= {CLIENT_STATUS, 12'(status_sent)};
      status_sent <= status_sent + 1;
      @(posedge clk);
      while (!status_grant) @(posedge clk);
      status_req.request <= 1'b0;
   endtask

   // Almost-full goes high about one cycle in every n until the frame drains
   task automatic almostfull_noise(input int n);
      while (!frame_done()) begin
         @(posedge clk);
         tx0_almostfull <= ($urandom % n == 0);
      end
      @(posedge clk);
      tx0_almostfull <= 1'b0;
   endtask

   initial begin
      resetb         = 1'b0;
      csr            = '0;
      status_req     = '0;
      tx0_almostfull = 1'b0;
      void'($urandom(56));
      status_base = $urandom;
      for (int f = 0; f < NUM_FRAMES; f++) begin
         frame_len[f] = 8 + int'($urandom % 33);
         total_lines += 2 * frame_len[f];
      end
      total_lines += NUM_POLLS + 1;

      repeat (2) @(posedge clk);
      resetb     <= 1'b1;
      csr.afu_en <= 1'b1;

      // Frame 0 runs with no back-pressure
      start_frame(frame_len[0]);
      wait_frame_done();

      // Frame 1 is paused by afu_en and must pick up where it stopped
      start_frame(frame_len[1]);
      repeat (4 + $urandom % 8) @(posedge clk);
      csr.afu_en <= 1'b0;
      repeat (16) @(posedge clk);
      csr.afu_en <= 1'b1;
      wait_frame_done();

      // Frame 2 sees a long almost-full burst and a status poll mid-frame
      start_frame(frame_len[2]);
      fork
         begin
            repeat (3) @(posedge clk);
            tx0_almostfull <= 1'b1;
            repeat (20) @(posedge clk);
            almostfull_noise(3);
         end
         begin
            repeat (5) @(posedge clk);
            issue_status_poll();
         end
      join

      // Polls on their own while both frame clients are idle
      repeat (NUM_POLLS) begin
         issue_status_poll();
         repeat (2) @(posedge clk);
      end
      while (next_line[2] < status_sent) @(posedge clk);

      // Frame 3 with light almost-full noise
      start_frame(frame_len[3]);
      repeat (3) @(posedge clk);
      almostfull_noise(4);
      repeat (4) @(posedge clk);

      if (next_line[0] != cur_lines || next_line[1] != cur_lines)
         note_error("Frame lines missing on tx0 at the end of the run");
      if (next_line[2] != status_sent)
         note_error("Status polls missing on tx0 at the end of the run");
      $display("Errors: %0d", error_count);
      if (error_count == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   // Watchdog sized from the total number of lines in the run
   initial begin
      wait (total_lines > 0);
      repeat (total_lines * 4 + 200) @(posedge clk);
      $display("Timeout: the read streams did not complete in time");
      $display("Errors: %0d", error_count + 1);
      $display("Checks failed");
      $finish;
   end

   // Packet checker
   // Each packet on tx0 is sorted by client id and compared with that client's next line
   always @(posedge clk) begin
      int         cid;
      int         limit;
      t_tx_header exp;
      cid = 3;
      if (csr.start) begin
         next_line[0] <= 0;
         next_line[1] <= 0;
         first_pkt = 1'b1;
      end
      if (resetb && tx0.rdvalid) begin
         cid   = int'(tx0.header.mdata[13:12]);
         limit = (cid < 2) ? cur_lines : status_sent;
         if (!afu_en_d)
            note_error("Packet issued while afu_en was low");
         if (cid > 2) begin
            note_error($sformatf("Packet carries unknown client id %0d", cid));
         end else if (next_line[cid] >= limit) begin
            note_error($sformatf("Unexpected extra packet from client %0d", cid));
         end else begin
            exp = expected_header(cid, next_line[cid]);
            if (tx0.header.opcode != exp.opcode)
               report_mismatch("tx0.header.opcode", 32'(exp.opcode), 32'(tx0.header.opcode));
            if (tx0.header.address != exp.address)
               report_mismatch("tx0.header.address", exp.address, tx0.header.address);
            if (tx0.header.mdata != exp.mdata)
               report_mismatch("tx0.header.mdata", 32'(exp.mdata), 32'(tx0.header.mdata));
            next_line[cid] <= next_line[cid] + 1;
         end
         // Both frame clients waiting means strict reader and writer turns
         if (cid < 2 && prev_valid && cid == prev_client &&
             next_line[0] < cur_lines && next_line[1] < cur_lines)
            note_error("Client got two grants in a row while both frame clients waited");
         if (cid < 2 && first_pkt) begin
            if (cid != 0)
               note_error("First packet of the frame did not come from the reader");
            first_pkt = 1'b0;
         end
         if (cid == 2 && (next_line[0] < cur_lines || next_line[1] < cur_lines))
            note_error("Status poll issued while a frame client still had lines pending");
      end
      // A status grant turns into a status packet one cycle later
      if (resetb && status_grant_d != (tx0.rdvalid && cid == 2))
         note_error("status_grant pulses and status packets on tx0 are out of step");
      // Packets granted under almost-full count against the slack of one episode
      if (af_d) begin
         if (resetb && tx0.rdvalid) begin
            af_packets = af_packets + 1;
            if (af_packets > CCI_AF_SLACK)
               note_error("More packets than the slack allows after almost-full rose");
         end
      end else begin
         af_packets = 0;
      end
      prev_valid     = resetb && tx0.rdvalid;
      prev_client    = cid;
      afu_en_d       = csr.afu_en;
      af_d           = tx0_almostfull;
      status_grant_d = status_grant;
   end

endmodule
